/* design/pwm_consts.svh */
`ifndef PWM_CONSTS_SVH
`define PWM_CONSTS_SVH

// ---------------------------------------------------------------------------
// channel count
// ---------------------------------------------------------------------------

// number of carrier and compare channels
`define PWM_CHANNELS 4

// ---------------------------------------------------------------------------
// register field widths
// ---------------------------------------------------------------------------

// carrier, period, initial value and compare
`define PWMCOUNT_WIDTH 16
// dead time in clock cycles
`define DTCOUNT_WIDTH 8
// event thinning counter
`define EVTCOUNT_WIDTH 3

`endif

/* design/pwm_pkg.sv */
`include "pwm_consts.svh"

package pwm_pkg;

    // -----------------------------------------------------------------------
    // field types
    // -----------------------------------------------------------------------

    // carrier value, period, initial value and compare level
    typedef logic [`PWMCOUNT_WIDTH-1:0] count_t;
    // dead time in clock cycles
    typedef logic [`DTCOUNT_WIDTH-1:0] dtime_t;
    // boundaries skipped between two events
    typedef logic [`EVTCOUNT_WIDTH-1:0] evtcount_t;
    // one bit per channel
    typedef logic [`PWM_CHANNELS-1:0] chan_vec_t;

    // carrier count modes, code 2'b11 is taken as up
    typedef enum logic [1:0] {
        COUNT_UP     = 2'b00,
        COUNT_DOWN   = 2'b01,
        COUNT_UPDOWN = 2'b10
    } count_mode_t;

endpackage

/* design/carrier_counter.sv */
module carrier_counter (
    input  logic                 clk,
    input  logic                 reset,
    // channel running
    input  logic                 enable,
    input  pwm_pkg::count_mode_t count_mode,
    input  pwm_pkg::count_t      period,
    input  pwm_pkg::count_t      initcarr,
    // events to skip, pulse on every (eventcount+1)-th boundary
    input  pwm_pkg::evtcount_t   eventcount,
    output pwm_pkg::count_t      carrier,
    output logic                 event_pulse
);

    pwm_pkg::count_t    carrier_next;
    logic               dir_up;
    logic               dir_up_next;
    logic               at_boundary;
    pwm_pkg::evtcount_t evt_cnt;

    // ------------------------------------------------------------------------
    // next carrier value per count mode
    // ------------------------------------------------------------------------
    always_comb begin
        carrier_next = carrier;
        dir_up_next  = dir_up;
        case (count_mode)
            pwm_pkg::COUNT_DOWN: begin
                // period down to 0, then reload
                if (carrier == '0) begin
                    carrier_next = period;
                end else begin
                    carrier_next = carrier - 1'b1;
                end
            end
            pwm_pkg::COUNT_UPDOWN: begin
                if (dir_up) begin
                    // top reached, turn around
                    if (carrier >= period) begin
                        dir_up_next  = 1'b0;
                        carrier_next = carrier - 1'b1;
                    end else begin
                        carrier_next = carrier + 1'b1;
                    end
                end else begin
                    // bottom reached, climb again
                    if (carrier == '0) begin
                        dir_up_next  = 1'b1;
                        carrier_next = carrier + 1'b1;
                    end else begin
                        carrier_next = carrier - 1'b1;
                    end
                end
            end
            default: begin
                // up and the spare code, 0 to period then wrap
                if (carrier >= period) begin
                    carrier_next = '0;
                end else begin
                    carrier_next = carrier + 1'b1;
                end
            end
        endcase
    end

    // boundary is period in up mode, 0 otherwise
    always_comb begin
        if (count_mode == pwm_pkg::COUNT_DOWN || count_mode == pwm_pkg::COUNT_UPDOWN) begin
            at_boundary = (carrier == '0);
        end else begin
            at_boundary = (carrier == period);
        end
    end

    // carrier and direction, parked on initcarr while stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            carrier <= '0;
            dir_up  <= 1'b1;
        end else if (!enable) begin
            carrier <= initcarr;
            dir_up  <= 1'b1;
        end else begin
            carrier <= carrier_next;
            dir_up  <= dir_up_next;
        end
    end

    // ------------------------------------------------------------------------
    // event thinning
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            evt_cnt     <= '0;
            event_pulse <= 1'b0;
        end else if (at_boundary) begin
            // last boundary of the group fires the event
            if (evt_cnt >= eventcount) begin
                evt_cnt     <= '0;
                event_pulse <= 1'b1;
            end else begin
                evt_cnt     <= evt_cnt + 1'b1;
                event_pulse <= 1'b0;
            end
        end else begin
            event_pulse <= 1'b0;
        end
    end

endmodule

/* design/dead_band_delay.sv */
module dead_band_delay (
    input  logic            clk,
    input  logic            reset,
    // undelayed gate request
    input  logic            gate_in,
    // rising-edge delay in cycles, 0 for none
    input  pwm_pkg::dtime_t dtime,
    output logic            gate_out
);

    // cycles gate_in has been high, saturating
    pwm_pkg::dtime_t hold_cnt;

    // ------------------------------------------------------------------------
    // hold counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt <= '0;
        end else if (!gate_in) begin
            hold_cnt <= '0;
        end else if (hold_cnt != '1) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // delayed gate
    // ------------------------------------------------------------------------
    // rises once the input has been high for dtime cycles
    // falls the cycle after the input drops, no delay on that edge
    // so a pulse of dtime cycles or less never shows
    always_ff @(posedge clk) begin
        if (reset) begin
            gate_out <= 1'b0;
        end else if (!gate_in) begin
            gate_out <= 1'b0;
        end else begin
            gate_out <= (hold_cnt >= dtime);
        end
    end

endmodule

/* design/pwm_channel.sv */
module pwm_channel (
    input  logic            clk,
    input  logic            reset,
    // channel running
    input  logic            enable,
    input  pwm_pkg::count_t carrier,
    input  pwm_pkg::count_t compare,
    // dead time on/off for both outputs
    input  logic            dt_onoff,
    input  pwm_pkg::dtime_t dtime_A,
    input  pwm_pkg::dtime_t dtime_B,
    // active levels of the two pins
    input  logic            logic_A,
    input  logic            logic_B,
    output logic            pwmout_A,
    output logic            pwmout_B
);

    logic            ref_q;
    logic            req_a;
    logic            req_b;
    pwm_pkg::dtime_t dt_a;
    pwm_pkg::dtime_t dt_b;
    logic            gate_a_out;
    logic            gate_b_out;

    // ------------------------------------------------------------------------
    // compare stage
    // ------------------------------------------------------------------------
    // reference high while carrier is below compare
    always_ff @(posedge clk) begin
        if (reset) begin
            ref_q <= 1'b0;
        end else begin
            ref_q <= (carrier < compare);
        end
    end

    // complementary requests, both dropped while stopped
    assign req_a = enable & ref_q;
    assign req_b = enable & ~ref_q;

    // dead time off means zero delay
    assign dt_a = dt_onoff ? dtime_A : '0;
    assign dt_b = dt_onoff ? dtime_B : '0;

    // ------------------------------------------------------------------------
    // dead band on each leg
    // ------------------------------------------------------------------------
    dead_band_delay gate_a (
        .clk      (clk),
        .reset    (reset),
        .gate_in  (req_a),
        .dtime    (dt_a),
        .gate_out (gate_a_out)
    );

    dead_band_delay gate_b (
        .clk      (clk),
        .reset    (reset),
        .gate_in  (req_b),
        .dtime    (dt_b),
        .gate_out (gate_b_out)
    );

    // active level while gated on, inverse otherwise
    assign pwmout_A = gate_a_out ~^ logic_A;
    assign pwmout_B = gate_b_out ~^ logic_B;

endmodule

/* design/interrupt_matrix.sv */
module interrupt_matrix (
    input  logic               clk,
    input  logic               reset,
    // thinned carrier events, one per channel
    input  pwm_pkg::chan_vec_t event_in,
    // channel selection for trigger and interrupt
    input  pwm_pkg::chan_vec_t matrix,
    input  logic               int_ack,
    output logic               trigger,
    output logic               interrupt
);

    // any selected channel fired this cycle
    logic hit;

    assign hit = |(event_in & matrix);

    // ------------------------------------------------------------------------
    // trigger pulse
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            trigger <= 1'b0;
        end else begin
            trigger <= hit;
        end
    end

    // ------------------------------------------------------------------------
    // sticky interrupt
    // ------------------------------------------------------------------------
    // rises with trigger, cleared by ack
    // a new hit beats an ack in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt <= 1'b0;
        end else if (hit) begin
            interrupt <= 1'b1;
        end else if (int_ack) begin
            interrupt <= 1'b0;
        end
    end

endmodule

/* design/pwm_top.sv */
`include "pwm_consts.svh"

module pwm_top (
    input  logic                                          clk,
    input  logic                                          reset,
    // global run bit
    input  logic                                          pwm_onoff,
    // flat register fields, channel 0 in the low bits
    input  logic [`PWM_CHANNELS*`PWMCOUNT_WIDTH-1:0]      period_x,
    input  logic [`PWM_CHANNELS*`PWMCOUNT_WIDTH-1:0]      initcarr_x,
    input  logic [`PWM_CHANNELS*`PWMCOUNT_WIDTH-1:0]      compare_x,
    input  logic [`PWM_CHANNELS*`DTCOUNT_WIDTH-1:0]       dtime_A_x,
    input  logic [`PWM_CHANNELS*`DTCOUNT_WIDTH-1:0]       dtime_B_x,
    input  logic [`PWM_CHANNELS*`EVTCOUNT_WIDTH-1:0]      eventcount_x,
    input  logic [`PWM_CHANNELS*$bits(pwm_pkg::count_mode_t)-1:0] countmode_x,
    // one bit per channel
    input  pwm_pkg::chan_vec_t                            dt_onoff_x,
    input  pwm_pkg::chan_vec_t                            carrier_onoff_x,
    input  pwm_pkg::chan_vec_t                            logic_A_x,
    input  pwm_pkg::chan_vec_t                            logic_B_x,
    input  pwm_pkg::chan_vec_t                            interrupt_matrix,
    input  logic                                          int_ack,
    output pwm_pkg::chan_vec_t                            pwmout_A_x,
    output pwm_pkg::chan_vec_t                            pwmout_B_x,
    output logic                                          trigger,
    output logic                                          interrupt
);

    // thinned events from all carriers
    pwm_pkg::chan_vec_t event_vec;

    // ------------------------------------------------------------------------
    // per-channel carrier and compare
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_chan
        pwm_pkg::count_t carrier;
        logic            run;

        // channel runs only with both global and own bit set
        assign run = pwm_onoff & carrier_onoff_x[i];

        carrier_counter u_carrier (
            .clk         (clk),
            .reset       (reset),
            .enable      (run),
            .count_mode  (pwm_pkg::count_mode_t'(countmode_x[2*i +: 2])),
            .period      (period_x[`PWMCOUNT_WIDTH*i +: `PWMCOUNT_WIDTH]),
            .initcarr    (initcarr_x[`PWMCOUNT_WIDTH*i +: `PWMCOUNT_WIDTH]),
            .eventcount  (eventcount_x[`EVTCOUNT_WIDTH*i +: `EVTCOUNT_WIDTH]),
            .carrier     (carrier),
            .event_pulse (event_vec[i])
        );

        pwm_channel u_channel (
            .clk      (clk),
            .reset    (reset),
            .enable   (run),
            .carrier  (carrier),
            .compare  (compare_x[`PWMCOUNT_WIDTH*i +: `PWMCOUNT_WIDTH]),
            .dt_onoff (dt_onoff_x[i]),
            .dtime_A  (dtime_A_x[`DTCOUNT_WIDTH*i +: `DTCOUNT_WIDTH]),
            .dtime_B  (dtime_B_x[`DTCOUNT_WIDTH*i +: `DTCOUNT_WIDTH]),
            .logic_A  (logic_A_x[i]),
            .logic_B  (logic_B_x[i]),
            .pwmout_A (pwmout_A_x[i]),
            .pwmout_B (pwmout_B_x[i])
        );
    end

    // ------------------------------------------------------------------------
    // trigger and interrupt
    // ------------------------------------------------------------------------
    interrupt_matrix u_intmat (
        .clk       (clk),
        .reset     (reset),
        .event_in  (event_vec),
        .matrix    (interrupt_matrix),
        .int_ack   (int_ack),
        .trigger   (trigger),
        .interrupt (interrupt)
    );

endmodule

/* tb/pwm_top_chk.sv */
module pwm_top_chk (
    input logic               clk,
    input logic               reset,
    input pwm_pkg::chan_vec_t pwmout_A_x,
    input pwm_pkg::chan_vec_t pwmout_B_x,
    input pwm_pkg::chan_vec_t logic_A_x,
    input pwm_pkg::chan_vec_t logic_B_x,
    input pwm_pkg::chan_vec_t interrupt_matrix,
    input logic               trigger,
    input logic               interrupt
);

    // count of failed assertions
    int fail_cnt = 0;

    pwm_pkg::chan_vec_t act_a;
    pwm_pkg::chan_vec_t act_b;

    // pin at its active level means the gate is on
    assign act_a = pwmout_A_x ~^ logic_A_x;
    assign act_b = pwmout_B_x ~^ logic_B_x;

    // ------------------------------------------------------------------------
    // gate and interrupt properties
    // ------------------------------------------------------------------------
    // both legs of one channel never conduct together
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        (act_a & act_b) == '0)
    else begin
        fail_cnt++;
        $error("gates A and B active together");
    end

    // back-to-back trigger only from more than one selected channel
    a_trig_single: assert property (@(posedge clk) disable iff (reset)
        trigger && $past(trigger) |-> $countones(interrupt_matrix) > 1)
    else begin
        fail_cnt++;
        $error("trigger longer than one cycle");
    end

    // interrupt only sets together with trigger
    a_int_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(interrupt) |-> trigger)
    else begin
        fail_cnt++;
        $error("interrupt rose without trigger");
    end

    // everything quiet right after a reset cycle
    a_reset_out: assert property (@(posedge clk)
        reset |=> (act_a == '0 && act_b == '0 && !trigger && !interrupt))
    else begin
        fail_cnt++;
        $error("outputs active after reset");
    end

endmodule

/* tb/tb_pwm_top.sv */
`include "pwm_consts.svh"

module tb_pwm_top;

    localparam int NCH   = `PWM_CHANNELS;
    localparam int NROWS = 7;

    // one test per row
    // expected pin counts are per carrier cycle, trigger count per window
    typedef struct {
        int                   ch;
        pwm_pkg::count_mode_t mode;
        pwm_pkg::count_t      period;
        pwm_pkg::count_t      compare;
        pwm_pkg::dtime_t      dt_a;
        pwm_pkg::dtime_t      dt_b;
        logic                 dt_on;
        logic                 pol_a;
        logic                 pol_b;
        pwm_pkg::evtcount_t   evc;
        logic                 mat;
        int                   exp_a;
        int                   exp_b;
        int                   exp_trig;
    } row_t;

    row_t rows [NROWS] = '{
        // ch mode  per cmp dtA dtB on pA pB evc mat  A  B trig
        '{0, pwm_pkg::COUNT_UP,      9, 4, 0, 0, 0, 1, 1, 0, 1, 4, 6, 2},
        '{1, pwm_pkg::COUNT_DOWN,   11, 5, 3, 2, 0, 1, 1, 1, 0, 5, 7, 0},
        '{2, pwm_pkg::COUNT_UPDOWN,  8, 3, 0, 0, 0, 1, 1, 2, 1, 5, 11, 2},
        '{3, pwm_pkg::COUNT_UP,     15, 6, 2, 3, 1, 0, 1, 3, 1, 4, 7, 2},
        '{0, pwm_pkg::COUNT_UPDOWN, 10, 4, 4, 5, 1, 1, 0, 0, 1, 3, 8, 2},
        '{1, pwm_pkg::COUNT_DOWN,    7, 2, 3, 1, 1, 0, 0, 1, 1, 0, 5, 2},
        '{2, pwm_pkg::COUNT_UP,     12, 5, 5, 0, 1, 1, 1, 4, 0, 0, 8, 0}
    };

    integer seed = 32'h5e986b7e;

    logic                                   clk = 1'b0;
    logic                                   reset;
    logic                                   pwm_onoff;
    logic [NCH*`PWMCOUNT_WIDTH-1:0]         period_x;
    logic [NCH*`PWMCOUNT_WIDTH-1:0]         initcarr_x;
    logic [NCH*`PWMCOUNT_WIDTH-1:0]         compare_x;
    logic [NCH*`DTCOUNT_WIDTH-1:0]          dtime_A_x;
    logic [NCH*`DTCOUNT_WIDTH-1:0]          dtime_B_x;
    logic [NCH*`EVTCOUNT_WIDTH-1:0]         eventcount_x;
    logic [NCH*2-1:0]                       countmode_x;
    pwm_pkg::chan_vec_t                     dt_onoff_x;
    pwm_pkg::chan_vec_t                     carrier_onoff_x;
    pwm_pkg::chan_vec_t                     logic_A_x;
    pwm_pkg::chan_vec_t                     logic_B_x;
    pwm_pkg::chan_vec_t                     interrupt_matrix;
    logic                                   int_ack;
    pwm_pkg::chan_vec_t                     pwmout_A_x;
    pwm_pkg::chan_vec_t                     pwmout_B_x;
    logic                                   trigger;
    logic                                   interrupt;

    pwm_top UUT (.*);

    bind pwm_top pwm_top_chk u_chk (
        .clk (clk), .reset (reset), .pwmout_A_x (pwmout_A_x), .pwmout_B_x (pwmout_B_x),
        .logic_A_x (logic_A_x), .logic_B_x (logic_B_x),
        .interrupt_matrix (interrupt_matrix), .trigger (trigger), .interrupt (interrupt)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic drive_edge;
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run;
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_count(input string name, input pwm_pkg::count_t got,
                               input pwm_pkg::count_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // up and down run period+1
    // up-down runs 2*period
    function automatic int cycle_len(input pwm_pkg::count_mode_t mode,
                                     input pwm_pkg::count_t per);
        if (mode == pwm_pkg::COUNT_UPDOWN)
            return 2 * int'(per);
        return int'(per) + 1;
    endfunction

    // active cycles per pin and trigger pulses
    // sampled mid-cycle
    task automatic measure_window(input int ch, input logic pa, input logic pb,
                                  input int cycles, output int na, output int nb,
                                  output int nt);
        na = 0;
        nb = 0;
        nt = 0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            na += (pwmout_A_x[ch] == pa);
            nb += (pwmout_B_x[ch] == pb);
            nt += trigger;
        end
    endtask

    task automatic wait_trigger;
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!trigger && n < 200);
        if (!trigger) begin
            $display("no trigger pulse seen within 200 cycles");
            abort_run();
        end
    endtask

    task automatic run_row(input row_t r);
        int len;
        int k;
        int na;
        int nb;
        int nt;
        len = cycle_len(r.mode, r.period);
        // window a multiple of eventcount+1 carrier cycles
        k = 2 * (int'(r.evc) + 1);
        drive_edge();
        pwm_onoff       = 1'b0;
        carrier_onoff_x = '0;
        drive_edge();
        int_ack = 1'b1;
        drive_edge();
        int_ack = 1'b0;
        period_x[16*r.ch +: 16]    = r.period;
        initcarr_x[16*r.ch +: 16]  = $unsigned($random(seed)) % (r.period + 1);
        compare_x[16*r.ch +: 16]   = r.compare;
        dtime_A_x[8*r.ch +: 8]     = r.dt_a;
        dtime_B_x[8*r.ch +: 8]     = r.dt_b;
        eventcount_x[3*r.ch +: 3]  = r.evc;
        countmode_x[2*r.ch +: 2]   = r.mode;
        dt_onoff_x[r.ch]           = r.dt_on;
        logic_A_x[r.ch]            = r.pol_a;
        logic_B_x[r.ch]            = r.pol_b;
        interrupt_matrix           = '0;
        interrupt_matrix[r.ch]     = r.mat;
        drive_edge();
        pwm_onoff              = 1'b1;
        carrier_onoff_x[r.ch]  = 1'b1;
        // settle over 3 carrier cycles
        repeat (3 * len) @(posedge clk);
        measure_window(r.ch, r.pol_a, r.pol_b, k * len, na, nb, nt);
        check_count($sformatf("pwmout_A_x[%0d]", r.ch), na, k * r.exp_a);
        check_count($sformatf("pwmout_B_x[%0d]", r.ch), nb, k * r.exp_b);
        check_count("trigger", nt, r.exp_trig);
        check_bit("interrupt", interrupt, r.mat);
    endtask

    // first failed assertion in the bound checker ends the run
    always @(UUT.u_chk.fail_cnt) begin
        if (UUT.u_chk.fail_cnt != 0) begin
            $display("assertion failed in the bound checker");
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        reset            = 1'b1;
        pwm_onoff        = 1'b0;
        period_x         = '0;
        initcarr_x       = '0;
        compare_x        = '0;
        dtime_A_x        = '0;
        dtime_B_x        = '0;
        eventcount_x     = '0;
        countmode_x      = '0;
        dt_onoff_x       = '0;
        carrier_onoff_x  = '0;
        logic_A_x        = pwm_pkg::chan_vec_t'('h5);
        logic_B_x        = pwm_pkg::chan_vec_t'('h3);
        interrupt_matrix = '1;
        int_ack          = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        // idle pins sit at the inverse of their polarity
        repeat (4) begin
            @(posedge clk);
            #1;
            for (int i = 0; i < NCH; i++) begin
                check_bit($sformatf("pwmout_A_x[%0d]", i), pwmout_A_x[i], ~logic_A_x[i]);
                check_bit($sformatf("pwmout_B_x[%0d]", i), pwmout_B_x[i], ~logic_B_x[i]);
            end
            check_bit("trigger", trigger, 1'b0);
            check_bit("interrupt", interrupt, 1'b0);
        end
        for (int i = 0; i < NROWS; i++)
            run_row(rows[i]);
        // interrupt acknowledge
        // channel 0 left running with its matrix bit set
        run_row(rows[0]);
        wait_trigger();
        check_bit("interrupt", interrupt, 1'b1);
        drive_edge();
        check_bit("interrupt", interrupt, 1'b1);
        int_ack = 1'b1;
        @(posedge clk);
        #1;
        check_bit("interrupt", interrupt, 1'b0);
        #1;
        int_ack = 1'b0;
        wait_trigger();
        check_bit("interrupt", interrupt, 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog sized from the table
    // margin covers reset and acknowledge test
    initial begin
        int limit;
        limit = 500;
        for (int i = 0; i < NROWS; i++)
            limit += (3 + 2 * (int'(rows[i].evc) + 1)) *
                     cycle_len(rows[i].mode, rows[i].period) + 8;
        #(limit * 40);
        $display("simulation did not finish in time");
        abort_run();
    end

endmodule

/* src.f */
+incdir+design
design/pwm_pkg.sv
design/carrier_counter.sv
design/dead_band_delay.sv
design/pwm_channel.sv
design/interrupt_matrix.sv
design/pwm_top.sv
tb/pwm_top_chk.sv
tb/tb_pwm_top.sv

/* Bender.yml */
package:
  name: pwm_top

sources:
  - include_dirs:
      - design
    files:
      - design/pwm_pkg.sv
      - design/carrier_counter.sv
      - design/dead_band_delay.sv
      - design/pwm_channel.sv
      - design/interrupt_matrix.sv
      - design/pwm_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/pwm_top_chk.sv
      - tb/tb_pwm_top.sv
